//--- hw/smc_mac_pkg.sv
package smc_mac_pkg;

  //--------------------------------------------------------------------------
  // data path widths
  //--------------------------------------------------------------------------

  localparam int data_w = 32;        // internal and external data word
  localparam int byte_w = 8;         // one byte lane

  // most accesses per transfer, 32-bit transfer on an 8-bit bus
  localparam int max_accesses = 4;

  //--------------------------------------------------------------------------
  // size encodings
  //--------------------------------------------------------------------------

  // transfer size, code is log2 of the byte count
  typedef enum logic [1:0]
  {
    xsiz_8  = 2'b00,
    xsiz_16 = 2'b01,
    xsiz_32 = 2'b10                  // 2'b11 reserved
  } xfer_size_t;

  // external bus width, same log2 coding as the transfer size
  typedef enum logic [1:0]
  {
    bsiz_8  = 2'b00,
    bsiz_16 = 2'b01,
    bsiz_32 = 2'b10                  // 2'b11 reserved
  } bus_size_t;

  //--------------------------------------------------------------------------
  // access counter
  //--------------------------------------------------------------------------

  // accesses still to go after the current one
  typedef logic [$clog2(max_accesses)-1:0] access_cnt_t;

endpackage

//--- hw/mac_sequencer.sv
`timescale 1ns/1ps

module mac_sequencer
(
  input  logic                      sys_clk11,
  input  logic                      n_sys_reset11,
  input  logic                      req_valid,
  input  logic                      req_write,
  input  smc_mac_pkg::xfer_size_t   req_xfer_size,
  input  smc_mac_pkg::bus_size_t    req_bus_size,
  output logic                      req_ready,
  output logic                      mem_valid,
  output logic                      mem_write,
  input  logic                      mem_ready,
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output logic                      req_fire,
  output logic                      beat_fire,
  output smc_mac_pkg::access_cnt_t  access_cnt,
  output smc_mac_pkg::xfer_size_t   cur_xfer_size,
  output smc_mac_pkg::bus_size_t    cur_bus_size
);

  import smc_mac_pkg::*;

  typedef enum logic [1:0]
  {
    st_idle,                         // waiting for a request
    st_access,                       // external accesses running
    st_respond                       // response held for the requester
  } state_t;

  state_t       state;
  logic         rsp_fire;
  access_cnt_t  cnt_load;            // accesses minus one for the new request

  //--------------------------------------------------------------------------
  // access size decision
  //--------------------------------------------------------------------------

  // transfer bytes over bus bytes, at least one access
  function automatic access_cnt_t count_load(xfer_size_t xsiz, bus_size_t bsiz);
    access_cnt_t cnt;
    case ({xsiz, bsiz})
      {xsiz_16, bsiz_8}:  cnt = 2'd1;        // two byte accesses
      {xsiz_32, bsiz_16}: cnt = 2'd1;        // two halfword accesses
      {xsiz_32, bsiz_8}:  cnt = 2'd3;        // four byte accesses
      default:            cnt = 2'd0;        // bus at least as wide
    endcase
    return cnt;
  endfunction

  assign cnt_load = count_load(req_xfer_size, req_bus_size);

  //--------------------------------------------------------------------------
  // handshakes and state decode
  //--------------------------------------------------------------------------

  assign req_ready = (state == st_idle);
  assign mem_valid = (state == st_access);
  assign rsp_valid = (state == st_respond);

  assign req_fire  = req_valid & req_ready;
  assign beat_fire = mem_valid & mem_ready;
  assign rsp_fire  = rsp_valid & rsp_ready;

  //--------------------------------------------------------------------------
  // controller
  //--------------------------------------------------------------------------

  always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
  begin
    if (!n_sys_reset11)
    begin
      state         <= st_idle;
      access_cnt    <= '0;
      mem_write     <= 1'b0;
      cur_xfer_size <= xsiz_8;
      cur_bus_size  <= bsiz_8;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (req_fire)
          begin
            state         <= st_access;
            access_cnt    <= cnt_load;
            mem_write     <= req_write;      // held for every access
            cur_xfer_size <= req_xfer_size;
            cur_bus_size  <= req_bus_size;
          end
        end
        st_access:
        begin
          if (beat_fire)
          begin
            if (access_cnt == '0)
              state <= st_respond;           // last beat done
            else
              access_cnt <= access_cnt - 1'b1;
          end
        end
        st_respond:
        begin
          if (rsp_fire)
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // reserved size codes never enter the controller
  legal_sizes_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    req_fire |-> (req_xfer_size inside {xsiz_8, xsiz_16, xsiz_32}) &&
                 (req_bus_size inside {bsiz_8, bsiz_16, bsiz_32}))
    else $error("accepted request with reserved size code");

  one_phase_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    !(mem_valid && rsp_valid))
    else $error("mem_valid and rsp_valid high together");

  // count frozen while the memory stalls
  cnt_hold_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (mem_valid && !mem_ready) |=> $stable(access_cnt))
    else $error("access_cnt moved during a memory stall");

endmodule

//--- hw/mac_write_lanes.sv
`timescale 1ns/1ps

module mac_write_lanes
(
  input  logic                              sys_clk11,
  input  logic                              n_sys_reset11,
  input  logic                              req_fire,
  input  logic                              beat_fire,
  input  logic [smc_mac_pkg::data_w-1:0]    req_wdata,
  input  smc_mac_pkg::xfer_size_t           req_xfer_size,
  input  smc_mac_pkg::bus_size_t            cur_bus_size,
  output logic [smc_mac_pkg::data_w-1:0]    mem_wdata
);

  import smc_mac_pkg::*;

  logic [data_w-1:0] wr_shift;     // transfer data, ms slice at the top
  xfer_size_t        wr_xfer_size; // size of the write in flight
  logic [1:0]        slice_code;   // log2 bytes of one access
  int                xfer_bits;
  int                slice_bits;
  int                bus_bits;

  //--------------------------------------------------------------------------
  // slice widths
  //--------------------------------------------------------------------------

  // the narrower of bus and transfer sets the slice
  assign slice_code = (wr_xfer_size < cur_bus_size) ? wr_xfer_size : cur_bus_size;
  assign slice_bits = byte_w << slice_code;
  assign bus_bits   = byte_w << cur_bus_size;
  assign xfer_bits  = byte_w << req_xfer_size;    // for the new request only

  //--------------------------------------------------------------------------
  // write data register
  //--------------------------------------------------------------------------

  // left justified so the next slice always sits in the top bits
  // bits above the transfer width fall off the top
  always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
  begin
    if (!n_sys_reset11)
    begin
      wr_shift     <= '0;
      wr_xfer_size <= xsiz_8;
    end
    else if (req_fire)
    begin
      wr_shift     <= req_wdata << (data_w - xfer_bits);
      wr_xfer_size <= req_xfer_size;
    end
    else if (beat_fire)
      wr_shift <= wr_shift << bus_bits;            // next slice up top
  end

  // top slice brought down to the low lanes, zeros above
  assign mem_wdata = wr_shift >> (data_w - slice_bits);

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // lanes only move on an accept or a completed access
  wdata_hold_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (!req_fire && !beat_fire) |=> $stable(mem_wdata))
    else $error("mem_wdata changed without a handshake");

endmodule

//--- hw/mac_read_assembler.sv
`timescale 1ns/1ps

module mac_read_assembler
(
  input  logic                              sys_clk11,
  input  logic                              n_sys_reset11,
  input  logic                              beat_fire,
  input  smc_mac_pkg::access_cnt_t          access_cnt,
  input  smc_mac_pkg::xfer_size_t           cur_xfer_size,
  input  smc_mac_pkg::bus_size_t            cur_bus_size,
  input  logic [smc_mac_pkg::data_w-1:0]    mem_rdata,
  output logic [smc_mac_pkg::data_w-1:0]    rsp_rdata
);

  import smc_mac_pkg::*;

  logic [data_w-1:0] rd_shift;     // beats collected so far
  logic [data_w-1:0] rd_next;      // shift register after this beat
  logic [data_w-1:0] beat_mask;
  logic [data_w-1:0] rd_wide;      // replicated result
  logic [1:0]        beat_code;    // log2 bytes per beat
  logic              last_beat;
  int                beat_bits;

  //--------------------------------------------------------------------------
  // beat width
  //--------------------------------------------------------------------------

  // bus wider than the transfer still gives one transfer-width beat
  assign beat_code = (cur_xfer_size < cur_bus_size) ? cur_xfer_size : cur_bus_size;
  assign beat_bits = byte_w << beat_code;
  assign beat_mask = {data_w{1'b1}} >> (data_w - beat_bits);

  assign last_beat = beat_fire && (access_cnt == '0);

  //--------------------------------------------------------------------------
  // beat collection
  //--------------------------------------------------------------------------

  // first beat is the ms slice, so older beats move up
  assign rd_next = (rd_shift << beat_bits) | (mem_rdata & beat_mask);

  always_ff @(posedge sys_clk11)
  begin
    if (beat_fire)
      rd_shift <= rd_next;
  end

  //--------------------------------------------------------------------------
  // replication
  //--------------------------------------------------------------------------

  // narrow reads copied across every lane of the word
  always_comb
  begin
    case (cur_xfer_size)
      xsiz_8:  rd_wide = {4{rd_next[byte_w-1:0]}};
      xsiz_16: rd_wide = {2{rd_next[2*byte_w-1:0]}};
      default: rd_wide = rd_next;                  // full word as built
    endcase
  end

  //--------------------------------------------------------------------------
  // response data register
  //--------------------------------------------------------------------------

  always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
  begin
    if (!n_sys_reset11)
      rsp_rdata <= '0;
    else if (last_beat)
      rsp_rdata <= rd_wide;            // valid along with rsp_valid
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // response data frozen from last beat through the response handshake
  rdata_hold_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    !last_beat |=> $stable(rsp_rdata))
    else $error("rsp_rdata changed outside the last beat");

endmodule

//--- hw/smc_mac.sv
`timescale 1ns/1ps

module smc_mac
(
  input  logic                              sys_clk11,
  input  logic                              n_sys_reset11,
  // request port
  input  logic                              req_valid,
  input  logic                              req_write,
  input  smc_mac_pkg::xfer_size_t           req_xfer_size,
  input  smc_mac_pkg::bus_size_t            req_bus_size,
  input  logic [smc_mac_pkg::data_w-1:0]    req_wdata,
  output logic                              req_ready,
  // memory port
  output logic                              mem_valid,
  output logic                              mem_write,
  output logic [smc_mac_pkg::data_w-1:0]    mem_wdata,
  input  logic                              mem_ready,
  input  logic [smc_mac_pkg::data_w-1:0]    mem_rdata,
  // response port
  output logic                              rsp_valid,
  output logic [smc_mac_pkg::data_w-1:0]    rsp_rdata,
  input  logic                              rsp_ready
);

  import smc_mac_pkg::*;

  logic         req_fire;          // request accepted
  logic         beat_fire;         // one access done
  access_cnt_t  access_cnt;
  xfer_size_t   cur_xfer_size;
  bus_size_t    cur_bus_size;

  //--------------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------------

  mac_sequencer mac_sequencer_inst
  (
    .sys_clk11     (sys_clk11),
    .n_sys_reset11 (n_sys_reset11),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_xfer_size (req_xfer_size),
    .req_bus_size  (req_bus_size),
    .req_ready     (req_ready),
    .mem_valid     (mem_valid),
    .mem_write     (mem_write),
    .mem_ready     (mem_ready),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .req_fire      (req_fire),
    .beat_fire     (beat_fire),
    .access_cnt    (access_cnt),
    .cur_xfer_size (cur_xfer_size),
    .cur_bus_size  (cur_bus_size)
  );

  //--------------------------------------------------------------------------
  // data paths
  //--------------------------------------------------------------------------

  mac_write_lanes mac_write_lanes_inst
  (
    .sys_clk11     (sys_clk11),
    .n_sys_reset11 (n_sys_reset11),
    .req_fire      (req_fire),
    .beat_fire     (beat_fire),
    .req_wdata     (req_wdata),
    .req_xfer_size (req_xfer_size),
    .cur_bus_size  (cur_bus_size),
    .mem_wdata     (mem_wdata)
  );

  mac_read_assembler mac_read_assembler_inst
  (
    .sys_clk11     (sys_clk11),
    .n_sys_reset11 (n_sys_reset11),
    .beat_fire     (beat_fire),
    .access_cnt    (access_cnt),
    .cur_xfer_size (cur_xfer_size),
    .cur_bus_size  (cur_bus_size),
    .mem_rdata     (mem_rdata),
    .rsp_rdata     (rsp_rdata)
  );

endmodule

//--- verif/tb_smc_mac.sv
`timescale 1ns/1ps

module tb_smc_mac;

  import smc_mac_pkg::*;

  localparam int num_xfers   = 200;
  localparam int cycle_limit = num_xfers * 40;   // worst transfer stays well under 40

  logic               sys_clk11;
  logic               n_sys_reset11;
  logic               req_valid;
  logic               req_write;
  xfer_size_t         req_xfer_size;
  bus_size_t          req_bus_size;
  logic [data_w-1:0]  req_wdata;
  logic               req_ready;
  logic               mem_valid;
  logic               mem_write;
  logic [data_w-1:0]  mem_wdata;
  logic               mem_ready;
  logic [data_w-1:0]  mem_rdata;
  logic               rsp_valid;
  logic [data_w-1:0]  rsp_rdata;
  logic               rsp_ready;

  logic [63:0]        lcg_state = 64'd70;
  int                 cycles = 0;

  // reference model, loaded at each request handshake
  logic               exp_write = 1'b0;
  xfer_size_t         exp_xfer_size = xsiz_8;
  bus_size_t          exp_bus_size = bsiz_8;
  logic [data_w-1:0]  exp_xfer_data = '0;          // write data cut to transfer width
  int                 exp_accesses = 1;
  int                 beats_done = 0;              // memory handshakes so far
  logic [data_w-1:0]  rd_beats [max_accesses] = '{default: '0};
  logic [data_w-1:0]  exp_slice;
  logic [data_w-1:0]  exp_rdata;

  smc_mac smc_mac_inst (.*);

  initial sys_clk11 = 1'b0;
  always #2 sys_clk11 = ~sys_clk11;             // 4 ns period

  //--------------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];                     // upper half, low bits cycle fast
  endfunction

  function automatic logic [data_w-1:0] low_mask(int bits);
    return (bits >= data_w) ? {data_w{1'b1}} : ((32'd1 << bits) - 32'd1);
  endfunction

  // transfer bytes over bus bytes, never below one
  function automatic int access_count(xfer_size_t xsiz, bus_size_t bsiz);
    int xbytes;
    int bbytes;
    xbytes = 1 << xsiz;
    bbytes = 1 << bsiz;
    return (xbytes > bbytes) ? xbytes / bbytes : 1;
  endfunction

  // slice idx of the transfer, ms slice first, in the low lanes
  function automatic logic [data_w-1:0] slice_for_access(logic [data_w-1:0] data,
                                                         xfer_size_t xsiz, bus_size_t bsiz,
                                                         int idx);
    int n;
    int bus_bits;
    n        = access_count(xsiz, bsiz);
    bus_bits = byte_w << bsiz;
    if (idx >= n)
      return '0;
    if (n == 1)
      return data;                               // whole zero extended transfer
    return (data >> ((n - 1 - idx) * bus_bits)) & low_mask(bus_bits);
  endfunction

  // beats joined ms first, then copied across the word
  function automatic logic [data_w-1:0] assemble_read(logic [data_w-1:0] beats [max_accesses],
                                                      xfer_size_t xsiz, bus_size_t bsiz);
    logic [data_w-1:0] val;
    logic [data_w-1:0] result;
    int                n;
    int                beat_bits;
    n         = access_count(xsiz, bsiz);
    beat_bits = (n == 1) ? (byte_w << xsiz) : (byte_w << bsiz);
    val       = '0;
    for (int i = 0; i < n; i++)
      val = (val << beat_bits) | (beats[i] & low_mask(beat_bits));
    case (xsiz)
      xsiz_8:  result = {4{val[7:0]}};
      xsiz_16: result = {2{val[15:0]}};
      default: result = val;
    endcase
    return result;
  endfunction

  task automatic report_error(string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  // inputs settle by the falling edge, so the handshake is known there
  task automatic wait_accept();
    logic done;
    done = 1'b0;
    while (!done)
    begin
      @(negedge sys_clk11);
      done = req_ready;
      @(posedge sys_clk11);
      #1;
    end
  endtask

  task automatic wait_response();
    logic done;
    done = 1'b0;
    while (!done)
    begin
      @(negedge sys_clk11);
      done = rsp_valid && rsp_ready;
      @(posedge sys_clk11);
      #1;
    end
  endtask

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------

  always @(posedge sys_clk11)
  begin
    if (req_valid && req_ready)
    begin
      exp_write     <= req_write;
      exp_xfer_size <= req_xfer_size;
      exp_bus_size  <= req_bus_size;
      exp_xfer_data <= req_wdata & low_mask(byte_w << req_xfer_size);
      exp_accesses  <= access_count(req_xfer_size, req_bus_size);
      beats_done    <= 0;
    end
    else if (mem_valid && mem_ready)
    begin
      rd_beats[beats_done] <= mem_rdata;         // what the responder handed over
      beats_done           <= beats_done + 1;
    end
  end

  always_comb
  begin
    exp_slice = slice_for_access(exp_xfer_data, exp_xfer_size, exp_bus_size, beats_done);
    exp_rdata = assemble_read(rd_beats, exp_xfer_size, exp_bus_size);
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  reset_idle_a : assert property (@(posedge sys_clk11)
    (!n_sys_reset11 || !$past(n_sys_reset11)) |-> req_ready && !mem_valid && !rsp_valid)
    else report_error("ports not idle during or right after reset");

  mem_start_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (req_valid && req_ready) |=> mem_valid && !req_ready)
    else report_error("mem_valid did not rise after request handshake");

  beat_limit_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (mem_valid && mem_ready) |-> beats_done < exp_accesses)
    else report_error("more memory accesses than the transfer needs");

  mem_next_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (mem_valid && mem_ready && beats_done < exp_accesses - 1) |=> mem_valid)
    else report_error("mem_valid dropped before the last access");

  rsp_start_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (mem_valid && mem_ready && beats_done == exp_accesses - 1) |=> !mem_valid && rsp_valid)
    else report_error("rsp_valid did not follow the last access");

  beat_total_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    $rose(rsp_valid) |-> beats_done == exp_accesses)
    else report_error("wrong number of memory accesses in the transfer");

  busy_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (mem_valid || rsp_valid) |-> !req_ready)
    else report_error("req_ready high while a transfer is in flight");

  ready_back_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (rsp_valid && rsp_ready) |=> req_ready && !rsp_valid)
    else report_error("req_ready not back after response handshake");

  write_flag_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    mem_valid |-> mem_write == exp_write)
    else report_error("mem_write does not match the request");

  write_slice_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (mem_valid && exp_write) |-> mem_wdata == exp_slice)
    else report_error("mem_wdata is not the expected slice");

  read_data_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (rsp_valid && !exp_write) |-> rsp_rdata == exp_rdata)
    else report_error("rsp_rdata differs from the assembled read");

  mem_hold_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (mem_valid && !mem_ready) |=> mem_valid && $stable(mem_wdata) && $stable(mem_write))
    else report_error("memory request moved during a stall");

  rsp_hold_a : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
    (rsp_valid && !rsp_ready) |=> rsp_valid && $stable(rsp_rdata))
    else report_error("response moved during a stall");

  //--------------------------------------------------------------------------
  // responders and timeout
  //--------------------------------------------------------------------------

  // 0 to 3 stall cycles after each access, fresh read data every cycle
  initial
  begin
    logic beat_seen;
    int   stall_left;
    stall_left = 0;
    @(posedge n_sys_reset11);
    forever
    begin
      @(negedge sys_clk11);
      beat_seen = mem_valid && mem_ready;
      @(posedge sys_clk11);
      #1;
      if (beat_seen)
        stall_left = next_rand() % 4;
      if (stall_left > 0)
      begin
        mem_ready  = 1'b0;
        stall_left = stall_left - 1;
      end
      else
        mem_ready = 1'b1;
      mem_rdata = next_rand();
    end
  end

  initial
  begin
    @(posedge n_sys_reset11);
    forever
    begin
      @(posedge sys_clk11);
      #1;
      rsp_ready = (next_rand() % 3) != 0;        // roughly one cycle in three stalled
    end
  end

  always @(posedge sys_clk11)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Error: run did not finish within %0d cycles, the DUT appears hung", cycles);
      $display("Regression failed");
      $fatal(1, "stopped on timeout");
    end
  end

  //--------------------------------------------------------------------------
  // requester
  //--------------------------------------------------------------------------

  initial
  begin
    logic [31:0] rnd;
    int          gap;
    n_sys_reset11 = 1'b0;
    req_valid     = 1'b0;
    req_write     = 1'b0;
    req_xfer_size = xsiz_8;
    req_bus_size  = bsiz_8;
    req_wdata     = '0;
    mem_ready     = 1'b0;
    mem_rdata     = '0;
    rsp_ready     = 1'b0;
    repeat (5) @(posedge sys_clk11);
    #1;
    n_sys_reset11 = 1'b1;
    for (int i = 0; i < num_xfers; i++)
    begin
      rnd           = next_rand();
      req_write     = rnd[31];
      req_xfer_size = xfer_size_t'(2'(rnd[15:8] % 3));   // legal codes only
      req_bus_size  = bus_size_t'(2'(rnd[23:16] % 3));
      req_wdata     = next_rand();
      req_valid     = 1'b1;
      wait_accept();
      req_valid     = 1'b0;
      req_write     = ~req_write;                 // fields free after accept
      req_wdata     = next_rand();
      wait_response();
      gap = next_rand() % 3;
      repeat (gap)
      begin
        @(posedge sys_clk11);
        #1;
      end
    end
    repeat (4) @(posedge sys_clk11);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- smc_mac.f
hw/smc_mac_pkg.sv
hw/mac_sequencer.sv
hw/mac_write_lanes.sv
hw/mac_read_assembler.sv
hw/smc_mac.sv
verif/tb_smc_mac.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_smc_mac
FILELIST   := smc_mac.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
